/* axi_delay_pkg.sv */
package axi_delay_pkg;

  // Bus widths shared by all channels
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // Write address beat
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [7:0]           len;
  } aw_chan_t;

  // Read address beat, same layout as AW
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [7:0]           len;
  } ar_chan_t;

  typedef struct packed {
    logic [DataWidth-1:0]   data;
    logic [DataWidth/8-1:0] strb;
    logic                   last;
  } w_chan_t;

  typedef struct packed {
    logic [IdWidth-1:0] id;
    logic [1:0]         resp;
  } b_chan_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic [1:0]           resp;
    logic                 last;
  } r_chan_t;

  // LFSR start value and longest random stall
  localparam logic [15:0] LfsrSeed       = 16'hACE1;
  localparam int unsigned MaxRandomDelay = 15;

endpackage

/* lfsr_16.sv */
`timescale 1ns/1ps

module lfsr_16 (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        en_i,
  output logic [15:0] rnd_o
);
  import axi_delay_pkg::*;

  // Galois taps for x^16 + x^14 + x^13 + x^11 + 1
  localparam logic [15:0] Taps = 16'hB400;

  logic [15:0] lfsr_q;
  logic [15:0] lfsr_d;

  // Shift right and fold the feedback bit into the tap positions
  assign lfsr_d = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? Taps : 16'h0000);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q <= LfsrSeed;
    end else if (en_i) begin
      lfsr_q <= lfsr_d;
    end
  end

  assign rnd_o = lfsr_q;

endmodule

/* stream_delay.sv */
`timescale 1ns/1ps

module stream_delay #(
  parameter type         payload_t   = logic,
  parameter bit          StallRandom = 1'b0,
  parameter int unsigned FixedDelay  = 1
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,
  input  payload_t payload_i,
  output logic     ready_o,
  output logic     valid_o,
  output payload_t payload_o,
  input  logic     ready_i
);
  import axi_delay_pkg::*;

  localparam int unsigned RndWidth  = $clog2(MaxRandomDelay + 1);
  localparam int unsigned MaxTarget = StallRandom ? MaxRandomDelay : FixedDelay;
  localparam int unsigned CntWidth  = (MaxTarget > 0) ? $clog2(MaxTarget + 1) : 1;

  typedef enum logic {
    StCount,
    StPass
  } state_e;

  state_e              state_q;
  state_e              state_d;
  logic [CntWidth-1:0] cnt_q;
  logic [CntWidth-1:0] cnt_d;
  logic [CntWidth-1:0] target;
  logic                hit;
  logic                passing;
  logic                xfer;

  if (StallRandom) begin : gen_random
    logic [15:0]         rnd;
    logic [CntWidth-1:0] target_q;

    // Advances only while traffic is waiting
    lfsr_16 i_lfsr_16 (
      .clk_i,
      .rst_i,
      .en_i  ( valid_i ),
      .rnd_o ( rnd     )
    );

    // Fresh draw on the first beat cycle, held value afterwards
    assign target = (cnt_q == '0) ? CntWidth'(rnd[RndWidth-1:0]) : target_q;

    always_ff @(posedge clk_i) begin
      if (valid_i && (cnt_q == '0)) begin
        target_q <= target;
      end
    end
  end else begin : gen_fixed
    assign target = CntWidth'(FixedDelay);
  end

  // Delay has run out for the beat at the input
  assign hit     = valid_i && (cnt_q == target);
  assign passing = (state_q == StPass) || hit;

  assign valid_o   = valid_i & passing;
  assign ready_o   = ready_i & valid_o;
  assign payload_o = payload_i;
  assign xfer      = valid_o & ready_i;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    if (passing) begin
      // Stay open under back-pressure until the handshake
      cnt_d   = '0;
      state_d = xfer ? StCount : StPass;
    end else if (valid_i) begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= StCount;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

/* axi_delayer.sv */
`timescale 1ns/1ps

module axi_delayer #(
  parameter bit          StallRandomInput  = 1'b0,
  parameter bit          StallRandomOutput = 1'b0,
  parameter int unsigned FixedDelayInput   = 1,
  parameter int unsigned FixedDelayOutput  = 1
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Upstream side, facing the AXI master
  input  logic                    aw_valid_i,
  input  axi_delay_pkg::aw_chan_t aw_chan_i,
  output logic                    aw_ready_o,

  input  logic                    w_valid_i,
  input  axi_delay_pkg::w_chan_t  w_chan_i,
  output logic                    w_ready_o,

  output logic                    b_valid_o,
  output axi_delay_pkg::b_chan_t  b_chan_o,
  input  logic                    b_ready_i,

  input  logic                    ar_valid_i,
  input  axi_delay_pkg::ar_chan_t ar_chan_i,
  output logic                    ar_ready_o,

  output logic                    r_valid_o,
  output axi_delay_pkg::r_chan_t  r_chan_o,
  input  logic                    r_ready_i,

  // Downstream side, facing the AXI slave
  output logic                    aw_valid_o,
  output axi_delay_pkg::aw_chan_t aw_chan_o,
  input  logic                    aw_ready_i,

  output logic                    w_valid_o,
  output axi_delay_pkg::w_chan_t  w_chan_o,
  input  logic                    w_ready_i,

  input  logic                    b_valid_i,
  input  axi_delay_pkg::b_chan_t  b_chan_i,
  output logic                    b_ready_o,

  output logic                    ar_valid_o,
  output axi_delay_pkg::ar_chan_t ar_chan_o,
  input  logic                    ar_ready_i,

  input  logic                    r_valid_i,
  input  axi_delay_pkg::r_chan_t  r_chan_i,
  output logic                    r_ready_o
);
  import axi_delay_pkg::*;

  // Request channels use the input delay
  stream_delay #(
    .payload_t   ( aw_chan_t        ),
    .StallRandom ( StallRandomInput ),
    .FixedDelay  ( FixedDelayInput  )
  ) i_stream_delay_aw (
    .clk_i,
    .rst_i,
    .valid_i   ( aw_valid_i ),
    .payload_i ( aw_chan_i  ),
    .ready_o   ( aw_ready_o ),
    .valid_o   ( aw_valid_o ),
    .payload_o ( aw_chan_o  ),
    .ready_i   ( aw_ready_i )
  );

  stream_delay #(
    .payload_t   ( w_chan_t         ),
    .StallRandom ( StallRandomInput ),
    .FixedDelay  ( FixedDelayInput  )
  ) i_stream_delay_w (
    .clk_i,
    .rst_i,
    .valid_i   ( w_valid_i ),
    .payload_i ( w_chan_i  ),
    .ready_o   ( w_ready_o ),
    .valid_o   ( w_valid_o ),
    .payload_o ( w_chan_o  ),
    .ready_i   ( w_ready_i )
  );

  stream_delay #(
    .payload_t   ( ar_chan_t        ),
    .StallRandom ( StallRandomInput ),
    .FixedDelay  ( FixedDelayInput  )
  ) i_stream_delay_ar (
    .clk_i,
    .rst_i,
    .valid_i   ( ar_valid_i ),
    .payload_i ( ar_chan_i  ),
    .ready_o   ( ar_ready_o ),
    .valid_o   ( ar_valid_o ),
    .payload_o ( ar_chan_o  ),
    .ready_i   ( ar_ready_i )
  );

  // Response channels run back toward the master with the output delay
  stream_delay #(
    .payload_t   ( b_chan_t          ),
    .StallRandom ( StallRandomOutput ),
    .FixedDelay  ( FixedDelayOutput  )
  ) i_stream_delay_b (
    .clk_i,
    .rst_i,
    .valid_i   ( b_valid_i ),
    .payload_i ( b_chan_i  ),
    .ready_o   ( b_ready_o ),
    .valid_o   ( b_valid_o ),
    .payload_o ( b_chan_o  ),
    .ready_i   ( b_ready_i )
  );

  stream_delay #(
    .payload_t   ( r_chan_t          ),
    .StallRandom ( StallRandomOutput ),
    .FixedDelay  ( FixedDelayOutput  )
  ) i_stream_delay_r (
    .clk_i,
    .rst_i,
    .valid_i   ( r_valid_i ),
    .payload_i ( r_chan_i  ),
    .ready_o   ( r_ready_o ),
    .valid_o   ( r_valid_o ),
    .payload_o ( r_chan_o  ),
    .ready_i   ( r_ready_i )
  );

endmodule

/* axi_delayer_assert.sv */
`timescale 1ns/1ps

module axi_delayer_assert #(
  parameter type payload_t = logic,
  parameter bit  Gapped    = 1'b0
) (
  input logic     clk_i,
  input logic     rst_i,
  input logic     valid_o,
  input logic     ready_o,
  input logic     ready_i,
  input payload_t payload_o
);

  // A stalled beat keeps valid_o up until the sink takes it
  valid_held: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> valid_o)
    else $error("valid_o dropped before ready_i");

  payload_held: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> $stable(payload_o))
    else $error("payload_o changed while stalled");

  // With a nonzero fixed delay the next beat waits again after a handshake
  delay_rearmed: assert property (@(posedge clk_i) disable iff (rst_i)
    Gapped && ready_o |=> !valid_o)
    else $error("valid_o high in the cycle after an upstream handshake");

endmodule

bind stream_delay axi_delayer_assert #(
  .payload_t ( payload_t                           ),
  .Gapped    ( !StallRandom && (FixedDelay > 0) )
) i_axi_delayer_assert (
  .clk_i,
  .rst_i,
  .valid_o,
  .ready_o,
  .ready_i,
  .payload_o
);

/* axi_delayer_tb.sv */
`timescale 1ns/1ps

module axi_delayer_tb;
  import axi_delay_pkg::*;

  localparam int NumChan       = 5;
  localparam int NumBeats      = 20;
  localparam int TimeoutCycles = 200;
  localparam int FixedIn       = 2;
  // Indices into the per-test error counters
  localparam int TReset   = 0;
  localparam int TFixed   = 1;
  localparam int TPayload = 2;
  localparam int TStall   = 3;
  localparam int TRandom  = 4;

  logic               clk_i = 1'b0;
  logic               rst_i;
  logic [NumChan-1:0] src_valid;
  logic [NumChan-1:0] snk_ready;
  logic [NumChan-1:0] out_valid;
  logic [NumChan-1:0] in_ready;
  logic [63:0]        src_data [NumChan];
  logic [63:0]        out_data [NumChan];
  aw_chan_t           aw_out;
  w_chan_t            w_out;
  ar_chan_t           ar_out;
  b_chan_t            b_out;
  r_chan_t            r_out;

  string       chan_name [NumChan] = '{"aw", "w", "ar", "b", "r"};
  string       test_name [5] = '{"reset", "fixed input delay", "payload integrity",
                                 "back-pressure", "random output delay"};
  int          errs [5];
  int          checks;
  int          cycle;
  int          releases;
  bit          running;
  bit          timed_out;
  bit [15:0]   lat_seen;
  logic [31:0] beat_salt;
  int          rx_idx [NumChan];
  int          lat_start [NumChan];
  bit          lat_busy [NumChan];
  bit          lat_done [NumChan];
  bit          stalled [NumChan];
  logic [63:0] held_data [NumChan];

  always #10 clk_i = ~clk_i;

  axi_delayer #(
    .StallRandomInput  ( 1'b0    ),
    .StallRandomOutput ( 1'b1    ),
    .FixedDelayInput   ( FixedIn )
  ) i_axi_delayer (
    .clk_i,
    .rst_i,
    .aw_valid_i ( src_valid[0] ), .aw_ready_o ( in_ready[0] ),
    .aw_chan_i  ( aw_chan_t'(src_data[0][43:0]) ),
    .w_valid_i  ( src_valid[1] ), .w_ready_o  ( in_ready[1] ),
    .w_chan_i   ( w_chan_t'(src_data[1][36:0]) ),
    .ar_valid_i ( src_valid[2] ), .ar_ready_o ( in_ready[2] ),
    .ar_chan_i  ( ar_chan_t'(src_data[2][43:0]) ),
    .b_valid_i  ( src_valid[3] ), .b_ready_o  ( in_ready[3] ),
    .b_chan_i   ( b_chan_t'(src_data[3][5:0]) ),
    .r_valid_i  ( src_valid[4] ), .r_ready_o  ( in_ready[4] ),
    .r_chan_i   ( r_chan_t'(src_data[4][38:0]) ),
    .aw_valid_o ( out_valid[0] ), .aw_ready_i ( snk_ready[0] ), .aw_chan_o ( aw_out ),
    .w_valid_o  ( out_valid[1] ), .w_ready_i  ( snk_ready[1] ), .w_chan_o  ( w_out  ),
    .ar_valid_o ( out_valid[2] ), .ar_ready_i ( snk_ready[2] ), .ar_chan_o ( ar_out ),
    .b_valid_o  ( out_valid[3] ), .b_ready_i  ( snk_ready[3] ), .b_chan_o  ( b_out  ),
    .r_valid_o  ( out_valid[4] ), .r_ready_i  ( snk_ready[4] ), .r_chan_o  ( r_out  )
  );

  assign out_data[0] = 64'(aw_out);
  assign out_data[1] = 64'(w_out);
  assign out_data[2] = 64'(ar_out);
  assign out_data[3] = 64'(b_out);
  assign out_data[4] = 64'(r_out);

  function automatic int chan_width(input int c);
    case (c)
      0, 2:    return $bits(aw_chan_t);
      1:       return $bits(w_chan_t);
      3:       return $bits(b_chan_t);
      default: return $bits(r_chan_t);
    endcase
  endfunction

  // Beat n of channel c, scrambled by the run salt and cut to the channel width
  function automatic logic [63:0] expected_beat(input int c, input int idx);
    logic [63:0] raw;
    raw = {beat_salt ^ (32'(idx) * 32'h9E37_79B9), beat_salt + 32'(c << 8) + 32'(idx)};
    return raw & ((64'd1 << chan_width(c)) - 64'd1);
  endfunction

  function automatic int beats_received();
    return rx_idx.sum();
  endfunction

  task automatic check_value(input int t, input string sig, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      $display("[FAIL] %0t %s expected %h got %h", $time, sig, exp, act);
      errs[t]++;
    end
  endtask

  task automatic check_true(input int t, input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("Error at %0t: %s", $time, msg);
      errs[t]++;
    end
  endtask

  task automatic check_idle_outputs();
    for (int c = 0; c < NumChan; c++) begin
      check_value(TReset, $sformatf("%s_valid_o", chan_name[c]), 64'd0, 64'(out_valid[c]));
      check_value(TReset, $sformatf("%s_ready_o", chan_name[c]), 64'd0, 64'(in_ready[c]));
    end
  endtask

  task automatic check_channel(input int c);
    int lat;
    bit in_xfer;
    bit out_xfer;
    in_xfer  = src_valid[c] && in_ready[c];
    out_xfer = out_valid[c] && snk_ready[c];
    if (src_valid[c] && !lat_busy[c]) begin
      lat_start[c] = cycle;
      lat_busy[c]  = 1'b1;
    end
    // First cycle of valid_o ends the latency count
    if (lat_busy[c] && out_valid[c] && !lat_done[c]) begin
      lat         = cycle - lat_start[c];
      lat_done[c] = 1'b1;
      if (c < 3) begin
        check_value(TFixed, $sformatf("%s_valid_o latency", chan_name[c]),
                    64'(FixedIn), 64'(lat));
      end else begin
        check_true(TRandom, lat <= MaxRandomDelay,
                   $sformatf("%s latency of %0d cycles is too long", chan_name[c], lat));
        if (lat <= MaxRandomDelay) lat_seen[lat] = 1'b1;
      end
    end
    if (stalled[c]) begin
      check_value(TStall, $sformatf("%s_valid_o", chan_name[c]), 64'd1, 64'(out_valid[c]));
      check_value(TStall, $sformatf("%s_chan_o", chan_name[c]), held_data[c], out_data[c]);
      if (snk_ready[c]) begin
        check_true(TStall, out_xfer,
                   $sformatf("%s stalled beat did not move when ready rose", chan_name[c]));
        releases++;
      end
    end
    if (!out_valid[c] || !snk_ready[c]) begin
      check_value(TStall, $sformatf("%s_ready_o", chan_name[c]), 64'd0, 64'(in_ready[c]));
    end
    check_true(TPayload, in_xfer == out_xfer,
               $sformatf("%s handshakes on the two sides do not line up", chan_name[c]));
    if (out_xfer) begin
      check_true(TPayload, rx_idx[c] < NumBeats,
                 $sformatf("%s delivered more beats than were sent", chan_name[c]));
      check_value(TPayload, $sformatf("%s_chan_o", chan_name[c]),
                  expected_beat(c, rx_idx[c]), out_data[c]);
      rx_idx[c]++;
      lat_busy[c] = 1'b0;
      lat_done[c] = 1'b0;
    end
    stalled[c]   = out_valid[c] && !snk_ready[c];
    held_data[c] = out_data[c];
  endtask

  // Compare process
  always @(posedge clk_i) begin
    cycle++;
    if (running) begin
      for (int c = 0; c < NumChan; c++) begin
        check_channel(c);
      end
    end
  end

  task automatic run_source(input int c);
    int waited;
    bit done;
    for (int idx = 0; idx < NumBeats; idx++) begin
      repeat ($urandom_range(0, 2)) @(negedge clk_i);
      src_valid[c] = 1'b1;
      src_data[c]  = expected_beat(c, idx);
      done   = 1'b0;
      waited = 0;
      while (!done && waited < TimeoutCycles) begin
        @(posedge clk_i);
        done = in_ready[c];
        waited++;
      end
      @(negedge clk_i);
      src_valid[c] = 1'b0;
      if (!done) begin
        $display("Timeout: %s source saw no ready_o for %0d cycles", chan_name[c], waited);
        timed_out = 1'b1;
        return;
      end
    end
  endtask

  task automatic run_sink(input int c);
    while (rx_idx[c] < NumBeats && !timed_out) begin
      if ($urandom_range(0, 7) == 0) begin
        // Long stall, usually caught with valid_o up
        snk_ready[c] = 1'b0;
        repeat ($urandom_range(3, 10)) @(negedge clk_i);
      end
      snk_ready[c] = ($urandom_range(0, 3) != 0);
      @(negedge clk_i);
    end
  endtask

  initial begin
    int idle;
    int last_total;
    void'($urandom(32'h1629));
    beat_salt = $urandom;
    rst_i     = 1'b1;
    src_valid = '0;
    // Sinks stay ready through reset
    snk_ready = '1;
    for (int c = 0; c < NumChan; c++) begin
      src_data[c] = '0;
    end
    repeat (3) begin
      @(posedge clk_i);
      check_idle_outputs();
    end
    @(negedge clk_i);
    rst_i = 1'b0;
    @(posedge clk_i);
    check_idle_outputs();
    $display("Test %s finished with %0d errors", test_name[TReset], errs[TReset]);

    @(negedge clk_i);
    running = 1'b1;
    fork
      run_source(0);
      run_source(1);
      run_source(2);
      run_source(3);
      run_source(4);
      run_sink(0);
      run_sink(1);
      run_sink(2);
      run_sink(3);
      run_sink(4);
    join_none

    // Give up once no beat has moved for a full timeout window
    idle       = 0;
    last_total = 0;
    while (beats_received() < NumChan * NumBeats && !timed_out && idle < TimeoutCycles) begin
      @(negedge clk_i);
      if (beats_received() != last_total) begin
        last_total = beats_received();
        idle       = 0;
      end else begin
        idle++;
      end
    end
    if (!timed_out && beats_received() < NumChan * NumBeats) begin
      $display("Timeout: no beat got through the delayer for %0d cycles", idle);
      timed_out = 1'b1;
    end

    if (timed_out) begin
      $display("Run stopped after %0d of %0d beats", beats_received(), NumChan * NumBeats);
    end else begin
      check_true(TRandom, $countones(lat_seen) >= 2, "B and R showed fewer than two latencies");
      check_true(TStall, releases > 0, "no stalled beat was ever released");
    end
    for (int t = 1; t < 5; t++) begin
      $display("Test %s finished with %0d errors", test_name[t], errs[t]);
    end
    $display("Checks: %0d, errors: %0d", checks, errs.sum());
    if (!timed_out && errs.sum() == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* axi_delayer.f */
axi_delay_pkg.sv
lfsr_16.sv
stream_delay.sv
axi_delayer.sv
axi_delayer_assert.sv
axi_delayer_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= axi_delayer_tb
RTL_TOP   ?= axi_delayer
FILELIST  ?= axi_delayer.f
RTL_SRCS  ?= axi_delay_pkg.sv lfsr_16.sv stream_delay.sv axi_delayer.sv
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
